// ==== rtl/trace_pkg.sv ====
/*
 * shared widths, address types and packet encodings of the trace priority unit
 * XLEN fixes the address width, so all count widths follow from it
 */
`default_nettype none

package trace_pkg;

    // instruction address width
    localparam int unsigned XLEN = 32;
    // leading-bit count width, enough for 0..XLEN-1
    localparam int unsigned LZC_W = $clog2(XLEN);
    // kept-bit count width, must reach XLEN itself
    localparam int unsigned KEEP_W = LZC_W + 1;

    typedef logic [XLEN-1:0] addr_t;
    typedef logic [KEEP_W-1:0] keep_bits_t;
    typedef logic [LZC_W-1:0] lzc_cnt_t;

    // packet format, F_OPT_EXT doubles as the idle value
    typedef enum logic [1:0] {
        F_OPT_EXT    = 2'h0,
        F_DIFF_DELTA = 2'h1,
        F_ADDR_ONLY  = 2'h2,
        F_SYNC       = 2'h3
    } packet_format_e;

    // sync subformats, context is encoded but never generated here
    typedef enum logic [1:0] {
        SF_START   = 2'h0,
        SF_TRAP    = 2'h1,
        SF_CONTEXT = 2'h2,
        SF_SUPPORT = 2'h3
    } sync_subformat_e;

    // qualification status carried by support packets
    typedef enum logic [1:0] {
        NO_CHANGE  = 2'h0,
        ENDED_REP  = 2'h1,
        TRACE_LOST = 2'h2,
        ENDED_NTR  = 2'h3
    } qual_status_e;

endpackage

`default_nettype wire

// ==== rtl/trace_lzc.sv ====
/*
 * counts zeros above the highest set bit, WIDTH of 2 or more
 * cnt_o is meaningless while empty_o is high
 */
`timescale 1ns/1ps
`default_nettype none

module trace_lzc #(
    parameter int unsigned WIDTH = 32
) (
    input  logic [WIDTH-1:0]         in_i,
    output logic [$clog2(WIDTH)-1:0] cnt_o,
    output logic                     empty_o
);

    localparam int unsigned CNT_W = $clog2(WIDTH);

    // scan upwards, the highest set bit is written last
    always_comb begin
        cnt_o = '0;
        for (int unsigned i = 0; i < WIDTH; i++) begin
            if (in_i[i]) begin
                cnt_o = CNT_W'(WIDTH - 1 - i);
            end
        end
    end

    // no set bit at all
    assign empty_o = ~|in_i;

endmodule

`default_nettype wire

// ==== rtl/trace_addr_compress.sv ====
/*
 * number of low address bits that still sign-extend to the full address
 * purely combinational, valid in every cycle
 */
`timescale 1ns/1ps
`default_nettype none

module trace_addr_compress (
    input  trace_pkg::addr_t      addr_i,
    output trace_pkg::keep_bits_t keep_bits_o
);

    import trace_pkg::*;

    lzc_cnt_t zero_cnt, one_cnt, lead_cnt;
    logic     zero_empty, one_empty;

    // leading zeros of the address
    trace_lzc #(.WIDTH(XLEN)) u_lzc_zeros (
        .in_i   (addr_i),
        .cnt_o  (zero_cnt),
        .empty_o(zero_empty)
    );

    // leading ones, seen as zeros of the inverse
    trace_lzc #(.WIDTH(XLEN)) u_lzc_ones (
        .in_i   (~addr_i),
        .cnt_o  (one_cnt),
        .empty_o(one_empty)
    );

    // only one run is nonzero, the msb decides which
    assign lead_cnt = (zero_cnt > one_cnt) ? zero_cnt : one_cnt;

    // one copy of the sign bit stays so the receiver can re-extend
    assign keep_bits_o = (zero_empty || one_empty) ? keep_bits_t'(1)
                       : keep_bits_t'(XLEN) - keep_bits_t'(lead_cnt) + keep_bits_t'(1);

    // range check over both counters and the corner cases
    always_comb begin
        assert (keep_bits_o >= keep_bits_t'(1) && keep_bits_o <= keep_bits_t'(XLEN))
            else $error("keep_bits out of range");
    end

endmodule

`default_nettype wire

// ==== rtl/trace_packet_select.sv ====
/*
 * combinational packet decision, zero latency, valid_i qualifies each cycle
 * reported and ended state only affects the decision of the following cycle
 */
`timescale 1ns/1ps
`default_nettype none

module trace_packet_select (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        valid_i,
    input  logic                        lc_exception_i,
    input  logic                        lc_updiscon_i,
    input  logic                        lc_final_qualified_i,
    input  logic                        tc_qualified_i,
    input  logic                        tc_exception_i,
    input  logic                        tc_retired_i,
    input  logic                        tc_first_qualified_i,
    input  logic                        tc_privchange_i,
    input  logic                        tc_gt_max_resync_i,
    input  logic                        tc_et_max_resync_i,
    input  logic                        tc_branch_map_empty_i,
    input  logic                        tc_branch_map_full_i,
    input  logic                        tc_enc_enabled_i,
    input  logic                        tc_enc_disabled_i,
    input  logic                        tc_opmode_change_i,
    input  logic                        nc_exception_i,
    input  logic                        nc_privchange_i,
    input  logic                        nc_branch_map_empty_i,
    input  logic                        nc_qualified_i,
    input  logic                        nc_retired_i,
    output logic                        valid_o,
    output trace_pkg::packet_format_e   format_o,
    output trace_pkg::sync_subformat_e  subformat_o,
    output logic                        thaddr_o,
    output logic                        lc_tc_sel_o,
    output logic                        resync_rst_o,
    output trace_pkg::qual_status_e     qual_status_o
);

    import trace_pkg::*;

    // state from the previous decision
    logic lc_ended_ntr_d, lc_ended_ntr_q;
    logic lc_ended_rep_d, lc_ended_rep_q;
    logic tc_reported_d, tc_reported_q;
    logic reported_we;

    // derived terms
    logic tc_exc_only;
    logic tc_er_n;
    logic tc_resync_br;
    logic nc_exc_only;
    logic nc_ppccd_br;
    logic support_req;
    packet_format_e addr_fmt;

    // exception without a retired instruction
    assign tc_exc_only  = tc_exception_i & ~tc_retired_i;
    assign tc_er_n      = tc_exception_i & tc_retired_i;
    // resync one step from timeout, branches pending
    assign tc_resync_br = tc_et_max_resync_i & ~tc_branch_map_empty_i;
    assign nc_exc_only  = nc_exception_i & ~nc_retired_i;
    assign nc_ppccd_br  = nc_privchange_i & ~nc_branch_map_empty_i;
    assign support_req  = tc_enc_enabled_i | tc_enc_disabled_i | tc_opmode_change_i
                        | lc_final_qualified_i;

    // address rule, branches pending need a differential packet
    assign addr_fmt = tc_branch_map_empty_i ? F_ADDR_ONLY : F_DIFF_DELTA;

    always_comb begin
        valid_o        = 1'b0;
        format_o       = F_OPT_EXT;
        subformat_o    = SF_START;
        thaddr_o       = 1'b0;
        lc_tc_sel_o    = 1'b0;
        resync_rst_o   = 1'b0;
        qual_status_o  = NO_CHANGE;
        lc_ended_ntr_d = 1'b0;
        lc_ended_rep_d = 1'b0;

        if (valid_i) begin
            if (support_req) begin
                // support packet wins over everything
                valid_o     = 1'b1;
                format_o    = F_SYNC;
                subformat_o = SF_SUPPORT;
                if (lc_ended_ntr_q) begin
                    qual_status_o = ENDED_NTR;
                end else if (lc_ended_rep_q) begin
                    qual_status_o = ENDED_REP;
                end
            end else if (tc_qualified_i) begin
                if (lc_exception_i) begin
                    // cause taken from last cycle, sel stays 0
                    valid_o      = 1'b1;
                    format_o     = F_SYNC;
                    resync_rst_o = 1'b1;
                    if (tc_exc_only) begin
                        subformat_o = SF_TRAP;
                    end else if (tc_reported_q) begin
                        subformat_o = SF_START;
                    end else begin
                        // trap not yet reported, carry its address
                        subformat_o = SF_TRAP;
                        thaddr_o    = 1'b1;
                    end
                end else if (tc_first_qualified_i || tc_privchange_i || tc_gt_max_resync_i) begin
                    valid_o      = 1'b1;
                    format_o     = F_SYNC;
                    subformat_o  = SF_START;
                    resync_rst_o = 1'b1;
                end else if (lc_updiscon_i) begin
                    valid_o        = 1'b1;
                    lc_ended_ntr_d = 1'b1;
                    if (tc_exc_only) begin
                        // cause from this cycle
                        format_o     = F_SYNC;
                        subformat_o  = SF_TRAP;
                        lc_tc_sel_o  = 1'b1;
                        resync_rst_o = 1'b1;
                    end else begin
                        format_o = addr_fmt;
                    end
                end else if (tc_resync_br || tc_er_n) begin
                    valid_o  = 1'b1;
                    format_o = addr_fmt;
                end else if (nc_exc_only || nc_ppccd_br || !nc_qualified_i) begin
                    valid_o        = 1'b1;
                    format_o       = addr_fmt;
                    // last qualified instruction
                    lc_ended_rep_d = ~nc_qualified_i;
                end else if (tc_branch_map_full_i) begin
                    valid_o  = 1'b1;
                    format_o = F_DIFF_DELTA;
                end
            end
        end
    end

    // reported memory only moves on trap without address or start outside exc-only
    assign reported_we = valid_o && format_o == F_SYNC
                      && ((subformat_o == SF_TRAP && !thaddr_o)
                          || (subformat_o == SF_START && !tc_exc_only));
    assign tc_reported_d = (subformat_o == SF_TRAP);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tc_reported_q  <= 1'b0;
            lc_ended_ntr_q <= 1'b0;
            lc_ended_rep_q <= 1'b0;
        end else begin
            if (reported_we) begin
                tc_reported_q <= tc_reported_d;
            end
            // ended flags live for exactly one cycle
            lc_ended_ntr_q <= lc_ended_ntr_d;
            lc_ended_rep_q <= lc_ended_rep_d;
        end
    end

    // downstream emitter relies on valid_i as the only qualifier
    a_valid_qualified: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !valid_i |-> !valid_o)
        else $error("packet flagged without valid_i");

    a_qual_support_only: assert property (@(posedge clk_i) disable iff (!rst_ni)
        qual_status_o != NO_CHANGE |-> (format_o == F_SYNC && subformat_o == SF_SUPPORT))
        else $error("qual_status set outside a support packet");

    a_thaddr_trap_only: assert property (@(posedge clk_i) disable iff (!rst_ni)
        thaddr_o |-> (valid_o && format_o == F_SYNC && subformat_o == SF_TRAP))
        else $error("thaddr set outside a trap packet");

endmodule

`default_nettype wire

// ==== rtl/trace_priority_top.sv ====
/*
 * mandatory packet selection only: no trigger, jump cache, context or lost reporting
 * no back-pressure, a packet shown with valid_o that downstream cannot take is lost
 */
`timescale 1ns/1ps
`default_nettype none

module trace_priority_top (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        valid_i,
    // last cycle flags
    input  logic                        lc_exception_i,
    input  logic                        lc_updiscon_i,
    input  logic                        lc_final_qualified_i,
    // this cycle flags
    input  logic                        tc_qualified_i,
    input  logic                        tc_exception_i,
    input  logic                        tc_retired_i,
    input  logic                        tc_first_qualified_i,
    input  logic                        tc_privchange_i,
    input  logic                        tc_gt_max_resync_i,
    input  logic                        tc_et_max_resync_i,
    input  logic                        tc_branch_map_empty_i,
    input  logic                        tc_branch_map_full_i,
    input  logic                        tc_enc_enabled_i,
    input  logic                        tc_enc_disabled_i,
    input  logic                        tc_opmode_change_i,
    // next cycle flags
    input  logic                        nc_exception_i,
    input  logic                        nc_privchange_i,
    input  logic                        nc_branch_map_empty_i,
    input  logic                        nc_qualified_i,
    input  logic                        nc_retired_i,
    // address to compress
    input  trace_pkg::addr_t            addr_i,
    // packet decision
    output logic                        valid_o,
    output trace_pkg::packet_format_e   format_o,
    output trace_pkg::sync_subformat_e  subformat_o,
    output logic                        thaddr_o,
    output logic                        lc_tc_sel_o,
    output logic                        resync_rst_o,
    output trace_pkg::qual_status_e     qual_status_o,
    output trace_pkg::keep_bits_t       keep_bits_o
);

    // packet choice, holds the reported and ended state
    trace_packet_select u_packet_select (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .valid_i              (valid_i),
        .lc_exception_i       (lc_exception_i),
        .lc_updiscon_i        (lc_updiscon_i),
        .lc_final_qualified_i (lc_final_qualified_i),
        .tc_qualified_i       (tc_qualified_i),
        .tc_exception_i       (tc_exception_i),
        .tc_retired_i         (tc_retired_i),
        .tc_first_qualified_i (tc_first_qualified_i),
        .tc_privchange_i      (tc_privchange_i),
        .tc_gt_max_resync_i   (tc_gt_max_resync_i),
        .tc_et_max_resync_i   (tc_et_max_resync_i),
        .tc_branch_map_empty_i(tc_branch_map_empty_i),
        .tc_branch_map_full_i (tc_branch_map_full_i),
        .tc_enc_enabled_i     (tc_enc_enabled_i),
        .tc_enc_disabled_i    (tc_enc_disabled_i),
        .tc_opmode_change_i   (tc_opmode_change_i),
        .nc_exception_i       (nc_exception_i),
        .nc_privchange_i      (nc_privchange_i),
        .nc_branch_map_empty_i(nc_branch_map_empty_i),
        .nc_qualified_i       (nc_qualified_i),
        .nc_retired_i         (nc_retired_i),
        .valid_o              (valid_o),
        .format_o             (format_o),
        .subformat_o          (subformat_o),
        .thaddr_o             (thaddr_o),
        .lc_tc_sel_o          (lc_tc_sel_o),
        .resync_rst_o         (resync_rst_o),
        .qual_status_o        (qual_status_o)
    );

    // compression runs every cycle, independent of valid_i
    trace_addr_compress u_addr_compress (
        .addr_i     (addr_i),
        .keep_bits_o(keep_bits_o)
    );

endmodule

`default_nettype wire

// ==== verif/trace_ref_model.svh ====
/*
 * reference model of the packet priority rules and the address compression
 * reads the testbench input variables, so include it after their declarations
 */
`ifndef TRACE_REF_MODEL_SVH
`define TRACE_REF_MODEL_SVH

// model copy of the reported and ended memory
logic m_ended_ntr;
logic m_ended_rep;
logic m_reported;
// next state, worked out together with the prediction
logic m_ended_ntr_nxt;
logic m_ended_rep_nxt;
logic m_reported_we;
logic m_reported_nxt;

// expected outputs of the current cycle
logic            exp_valid;
packet_format_e  exp_format;
sync_subformat_e exp_subformat;
logic            exp_thaddr;
logic            exp_sel;
logic            exp_resync;
qual_status_e    exp_qual;
keep_bits_t      exp_keep;

// run of bits equal to the msb, counted from the top
function automatic keep_bits_t model_keep_bits(input addr_t a);
    int unsigned run;
    logic        in_run;
    run    = 0;
    in_run = 1'b1;
    for (int i = XLEN - 1; i >= 0; i--) begin
        if (in_run && a[i] == a[XLEN-1]) begin
            run++;
        end else begin
            in_run = 1'b0;
        end
    end
    // all zeros or all ones
    if (run == XLEN) begin
        return keep_bits_t'(1);
    end
    return keep_bits_t'(XLEN - run + 1);
endfunction

// pending branches force the differential form
function automatic packet_format_e addr_rule(input logic map_empty);
    return map_empty ? F_ADDR_ONLY : F_DIFF_DELTA;
endfunction

task automatic emit_sync(input sync_subformat_e sf, input logic th, input logic sel);
    exp_valid     = 1'b1;
    exp_format    = F_SYNC;
    exp_subformat = sf;
    exp_thaddr    = th;
    exp_sel       = sel;
    // every trap or start sync asks for a resync restart
    exp_resync    = (sf != SF_SUPPORT);
endtask

task automatic emit_addr(input packet_format_e fmt);
    exp_valid  = 1'b1;
    exp_format = fmt;
endtask

task automatic reset_model();
    m_ended_ntr = 1'b0;
    m_ended_rep = 1'b0;
    m_reported  = 1'b0;
endtask

task automatic predict_packet();
    logic exc_only;
    logic er_n;
    logic resync_br;
    logic nc_exc;
    logic nc_priv_br;
    logic support;
    exc_only   = tc_exception_i && !tc_retired_i;
    er_n       = tc_exception_i && tc_retired_i;
    resync_br  = tc_et_max_resync_i && !tc_branch_map_empty_i;
    nc_exc     = nc_exception_i && !nc_retired_i;
    nc_priv_br = nc_privchange_i && !nc_branch_map_empty_i;
    support    = tc_enc_enabled_i || tc_enc_disabled_i || tc_opmode_change_i
              || lc_final_qualified_i;

    // idle values, also used whenever no packet is due
    exp_valid       = 1'b0;
    exp_format      = F_OPT_EXT;
    exp_subformat   = SF_START;
    exp_thaddr      = 1'b0;
    exp_sel         = 1'b0;
    exp_resync      = 1'b0;
    exp_qual        = NO_CHANGE;
    exp_keep        = model_keep_bits(addr_i);
    m_ended_ntr_nxt = 1'b0;
    m_ended_rep_nxt = 1'b0;
    m_reported_we   = 1'b0;
    m_reported_nxt  = m_reported;

    if (valid_i && support) begin
        emit_sync(SF_SUPPORT, 1'b0, 1'b0);
        if (m_ended_ntr) begin
            exp_qual = ENDED_NTR;
        end else if (m_ended_rep) begin
            exp_qual = ENDED_REP;
        end
    end else if (valid_i && tc_qualified_i) begin
        if (lc_exception_i) begin
            if (exc_only) begin
                emit_sync(SF_TRAP, 1'b0, 1'b0);
                m_reported_we  = 1'b1;
                m_reported_nxt = 1'b1;
            end else if (m_reported) begin
                emit_sync(SF_START, 1'b0, 1'b0);
                m_reported_we  = 1'b1;
                m_reported_nxt = 1'b0;
            end else begin
                emit_sync(SF_TRAP, 1'b1, 1'b0);
            end
        end else if (tc_first_qualified_i || tc_privchange_i || tc_gt_max_resync_i) begin
            emit_sync(SF_START, 1'b0, 1'b0);
            if (!exc_only) begin
                m_reported_we  = 1'b1;
                m_reported_nxt = 1'b0;
            end
        end else if (lc_updiscon_i) begin
            m_ended_ntr_nxt = 1'b1;
            if (exc_only) begin
                // cause select points at this cycle
                emit_sync(SF_TRAP, 1'b0, 1'b1);
                m_reported_we  = 1'b1;
                m_reported_nxt = 1'b1;
            end else begin
                emit_addr(addr_rule(tc_branch_map_empty_i));
            end
        end else if (resync_br || er_n) begin
            emit_addr(addr_rule(tc_branch_map_empty_i));
        end else if (nc_exc || nc_priv_br || !nc_qualified_i) begin
            emit_addr(addr_rule(tc_branch_map_empty_i));
            m_ended_rep_nxt = !nc_qualified_i;
        end else if (tc_branch_map_full_i) begin
            emit_addr(F_DIFF_DELTA);
        end
    end
endtask

// rising edge update of the model memory
task automatic update_model_state();
    if (!rst_ni) begin
        reset_model();
    end else begin
        m_ended_ntr = m_ended_ntr_nxt;
        m_ended_rep = m_ended_rep_nxt;
        if (m_reported_we) begin
            m_reported = m_reported_nxt;
        end
    end
endtask

`endif

// ==== verif/tb_trace_priority.sv ====
/*
 * random and directed test of the trace priority unit against a model
 * inputs change on the falling edge and outputs are checked 2 ns later
 */
`timescale 1ns/1ps
`default_nettype none

module tb_trace_priority;

    import trace_pkg::*;

    localparam int unsigned RANDOM_CYCLES = 3000;
    localparam int unsigned RESET_TIMEOUT = 20;
    localparam logic [31:0] SEED = 32'hc50d;

    logic clk_i;
    logic rst_ni;
    logic valid_i;
    logic lc_exception_i;
    logic lc_updiscon_i;
    logic lc_final_qualified_i;
    logic tc_qualified_i;
    logic tc_exception_i;
    logic tc_retired_i;
    logic tc_first_qualified_i;
    logic tc_privchange_i;
    logic tc_gt_max_resync_i;
    logic tc_et_max_resync_i;
    logic tc_branch_map_empty_i;
    logic tc_branch_map_full_i;
    logic tc_enc_enabled_i;
    logic tc_enc_disabled_i;
    logic tc_opmode_change_i;
    logic nc_exception_i;
    logic nc_privchange_i;
    logic nc_branch_map_empty_i;
    logic nc_qualified_i;
    logic nc_retired_i;
    addr_t addr_i;

    logic            valid_o;
    packet_format_e  format_o;
    sync_subformat_e subformat_o;
    logic            thaddr_o;
    logic            lc_tc_sel_o;
    logic            resync_rst_o;
    qual_status_e    qual_status_o;
    keep_bits_t      keep_bits_o;

    logic [31:0] lcg_state;
    int unsigned wait_cycles;
    // corner addresses and their kept bit counts
    addr_t       corner_addr [5];
    keep_bits_t  corner_keep [5];

    `include "trace_ref_model.svh"

    trace_priority_top DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever begin
            #5 clk_i = ~clk_i;
        end
    end

    // reset over 3 rising edges and released on a falling edge
    initial begin
        rst_ni = 1'b0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // high with a chance of sixteenths/16
    function automatic logic random_flag(input int unsigned sixteenths);
        logic [31:0] r;
        r = next_random();
        return 32'(r[27:24]) < sixteenths;
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "output mismatch, simulation stopped");
        end
    endtask

    task automatic check_outputs(input string test);
        compare($sformatf("%s valid", test), 32'(exp_valid), 32'(valid_o));
        compare($sformatf("%s format", test), 32'(exp_format), 32'(format_o));
        // subformat only carries meaning on a sync packet
        if (exp_valid && exp_format == F_SYNC) begin
            compare($sformatf("%s subformat", test), 32'(exp_subformat), 32'(subformat_o));
        end
        compare($sformatf("%s thaddr", test), 32'(exp_thaddr), 32'(thaddr_o));
        compare($sformatf("%s cause sel", test), 32'(exp_sel), 32'(lc_tc_sel_o));
        compare($sformatf("%s resync", test), 32'(exp_resync), 32'(resync_rst_o));
        compare($sformatf("%s qual", test), 32'(exp_qual), 32'(qual_status_o));
        compare($sformatf("%s keep bits", test), 32'(exp_keep), 32'(keep_bits_o));
    endtask

    // commit model state at the rising edge and move on to the drive edge
    task automatic next_cycle();
        @(posedge clk_i);
        update_model_state();
        @(negedge clk_i);
    endtask

    task automatic settle_and_check(input string test);
        #2;
        predict_packet();
        check_outputs(test);
    endtask

    // quiet flags with nothing due even when tc_qualified_i is high
    task automatic clear_inputs();
        valid_i               = 1'b0;
        lc_exception_i        = 1'b0;
        lc_updiscon_i         = 1'b0;
        lc_final_qualified_i  = 1'b0;
        tc_qualified_i        = 1'b0;
        tc_exception_i        = 1'b0;
        tc_retired_i          = 1'b0;
        tc_first_qualified_i  = 1'b0;
        tc_privchange_i       = 1'b0;
        tc_gt_max_resync_i    = 1'b0;
        tc_et_max_resync_i    = 1'b0;
        tc_branch_map_empty_i = 1'b1;
        tc_branch_map_full_i  = 1'b0;
        tc_enc_enabled_i      = 1'b0;
        tc_enc_disabled_i     = 1'b0;
        tc_opmode_change_i    = 1'b0;
        nc_exception_i        = 1'b0;
        nc_privchange_i       = 1'b0;
        nc_branch_map_empty_i = 1'b1;
        nc_qualified_i        = 1'b1;
        nc_retired_i          = 1'b0;
    endtask

    // support flags kept rare so the lower priorities get reached
    task automatic randomize_inputs();
        logic [31:0] pick;
        pick                  = next_random();
        valid_i               = random_flag(14);
        lc_exception_i        = random_flag(3);
        lc_updiscon_i         = random_flag(4);
        lc_final_qualified_i  = random_flag(1);
        tc_qualified_i        = random_flag(14);
        tc_exception_i        = random_flag(5);
        tc_retired_i          = random_flag(8);
        tc_first_qualified_i  = random_flag(2);
        tc_privchange_i       = random_flag(2);
        tc_gt_max_resync_i    = random_flag(2);
        tc_et_max_resync_i    = random_flag(4);
        tc_branch_map_empty_i = random_flag(8);
        tc_branch_map_full_i  = random_flag(4);
        tc_enc_enabled_i      = random_flag(1);
        tc_enc_disabled_i     = random_flag(1);
        tc_opmode_change_i    = random_flag(1);
        nc_exception_i        = random_flag(4);
        nc_privchange_i       = random_flag(3);
        nc_branch_map_empty_i = random_flag(8);
        nc_qualified_i        = random_flag(12);
        nc_retired_i          = random_flag(8);
        // sign-extended values give every kept bit count
        case (pick[2:0])
            3'd0: addr_i = '0;
            3'd1: addr_i = '1;
            default: addr_i = addr_t'($signed(next_random()) >>> pick[8:4]);
        endcase
    endtask

    task automatic wait_reset_release();
        wait_cycles = 0;
        while (rst_ni !== 1'b1) begin
            if (wait_cycles >= RESET_TIMEOUT) begin
                $display("reset was not released within %0d cycles", RESET_TIMEOUT);
                $display("Result: FAILED");
                $fatal(1, "reset release timeout");
            end
            next_cycle();
            clear_inputs();
            settle_and_check("reset idle");
            compare("reset idle format", 32'(F_OPT_EXT), 32'(format_o));
            compare("reset idle valid", 32'd0, 32'(valid_o));
            wait_cycles++;
        end
    endtask

    task automatic drive_lc_exception(input logic exc, input logic retired);
        clear_inputs();
        valid_i        = 1'b1;
        tc_qualified_i = 1'b1;
        lc_exception_i = 1'b1;
        tc_exception_i = exc;
        tc_retired_i   = retired;
    endtask

    task automatic drive_support();
        clear_inputs();
        valid_i              = 1'b1;
        lc_final_qualified_i = 1'b1;
    endtask

    initial begin
        lcg_state   = SEED;
        addr_i      = '0;
        corner_addr = '{32'h0, 32'hffff_ffff, 32'h1, 32'h8000_0000, 32'h7fff_ffff};
        corner_keep = '{6'd1, 6'd1, 6'd2, 6'd32, 6'd32};
        clear_inputs();
        reset_model();
        wait_reset_release();

        // first support packet sees no ended flag
        next_cycle();
        drive_support();
        settle_and_check("first support");
        compare("first support qual", 32'(NO_CHANGE), 32'(qual_status_o));

        // trap without address marks it reported and the start clears that
        next_cycle();
        drive_lc_exception(1'b1, 1'b0);
        settle_and_check("trap no address");
        compare("trap no address thaddr", 32'd0, 32'(thaddr_o));
        next_cycle();
        drive_lc_exception(1'b0, 1'b1);
        settle_and_check("reported start");
        compare("reported start subformat", 32'(SF_START), 32'(subformat_o));
        next_cycle();
        drive_lc_exception(1'b0, 1'b1);
        settle_and_check("unreported trap");
        compare("unreported trap subformat", 32'(SF_TRAP), 32'(subformat_o));
        compare("unreported trap thaddr", 32'd1, 32'(thaddr_o));

        // updiscon then support
        next_cycle();
        drive_lc_exception(1'b0, 1'b0);
        lc_exception_i = 1'b0;
        lc_updiscon_i  = 1'b1;
        settle_and_check("updiscon");
        next_cycle();
        drive_support();
        settle_and_check("ended ntr");
        compare("ended ntr qual", 32'(ENDED_NTR), 32'(qual_status_o));
        // last qualified then support
        next_cycle();
        drive_lc_exception(1'b0, 1'b0);
        lc_exception_i = 1'b0;
        nc_qualified_i = 1'b0;
        settle_and_check("last qualified");
        next_cycle();
        drive_support();
        settle_and_check("ended rep");
        compare("ended rep qual", 32'(ENDED_REP), 32'(qual_status_o));
        // idle cycle in between wipes the ntr flag
        next_cycle();
        drive_lc_exception(1'b0, 1'b0);
        lc_exception_i = 1'b0;
        lc_updiscon_i  = 1'b1;
        settle_and_check("updiscon again");
        next_cycle();
        clear_inputs();
        settle_and_check("idle gap ntr");
        next_cycle();
        drive_support();
        settle_and_check("after ntr gap");
        compare("after ntr gap qual", 32'(NO_CHANGE), 32'(qual_status_o));
        // and the rep flag as well
        next_cycle();
        drive_lc_exception(1'b0, 1'b0);
        lc_exception_i = 1'b0;
        nc_qualified_i = 1'b0;
        settle_and_check("last qualified again");
        next_cycle();
        clear_inputs();
        settle_and_check("idle gap rep");
        next_cycle();
        drive_support();
        settle_and_check("after rep gap");
        compare("after rep gap qual", 32'(NO_CHANGE), 32'(qual_status_o));

        // corner addresses with valid_i low
        for (int k = 0; k < 5; k++) begin
            next_cycle();
            clear_inputs();
            addr_i = corner_addr[k];
            settle_and_check("address corner");
            compare("address corner keep", 32'(corner_keep[k]), 32'(keep_bits_o));
        end

        for (int unsigned n = 0; n < RANDOM_CYCLES; n++) begin
            next_cycle();
            randomize_inputs();
            settle_and_check("random");
        end

        next_cycle();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verif
rtl/trace_pkg.sv
rtl/trace_lzc.sv
rtl/trace_addr_compress.sv
rtl/trace_packet_select.sv
rtl/trace_priority_top.sv
verif/tb_trace_priority.sv

// ==== run.sh ====
#!/bin/sh
# builds the trace priority testbench with Verilator and runs it
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_trace_priority -f sources.f; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_trace_priority; then
    echo "simulation reported a failure"
    exit 1
fi

exit 0
